//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int xlen = 64;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_branch    = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    // Nine kinds, so the field needs four bits
    typedef enum logic [3:0] {
        br_none, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } branch_t;

    typedef enum logic {
        a_rs1,
        a_pc
    } a_src_t;

    typedef enum logic [1:0] {
        b_rs2,
        b_imm,
        b_four
    } b_src_t;

endpackage

`default_nettype wire

//--- design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // Decode to execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_val;   // Already forwarded
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;       // Sign-extended
        alu_op_t         alu_op;
        a_src_t          a_src;
        b_src_t          b_src;
        logic            word;      // 32-bit "w" form
        branch_t         branch;
        logic [4:0]      rd;
        logic            reg_write;
    } dec_ex_t;

    // Execute to result
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            reg_write;
    } ex_res_t;

    // Retire report carries the result-stage payload as is
    typedef ex_res_t retire_t;

endpackage

`default_nettype wire

//--- design/pipe_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in && !flush;  // Squashed entry loads as a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            data <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [isa_pkg::xlen-1:0] rs1_data,
    output logic [isa_pkg::xlen-1:0] rs2_data,
    input  logic                    we,
    input  logic [4:0]              rd,
    input  logic [isa_pkg::xlen-1:0] wdata
);

    import isa_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;  // x0 stays zero
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- design/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  logic [31:0]              instr,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic [isa_pkg::xlen-1:0] rs1_data,
    input  logic [isa_pkg::xlen-1:0] rs2_data,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    input  logic                     ex_we,
    input  logic [4:0]               ex_rd,
    input  logic [isa_pkg::xlen-1:0] ex_result,
    input  logic                     res_we,
    input  logic [4:0]               res_rd,
    input  logic [isa_pkg::xlen-1:0] res_result,
    output pipe_pkg::dec_ex_t        dec
);

    import isa_pkg::*;

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic [xlen-1:0] imm_i, imm_u, imm_j, imm_b;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // funct3 to ALU op; sub only exists in the register form
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic sub_ok,
                                               input logic alt_bit);
        case (f3)
            3'b000:  return (sub_ok && alt_bit) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt_bit ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        dec.alu_op    = alu_add;
        dec.a_src     = a_rs1;
        dec.b_src     = b_rs2;
        dec.word      = 1'b0;
        dec.branch    = br_none;
        dec.reg_write = 1'b0;
        dec.imm       = imm_i;
        case (opcode)
            opc_op, opc_op_32: begin
                dec.alu_op    = alu_from_funct(funct3, 1'b1, alt);
                dec.word      = (opcode == opc_op_32);
                dec.reg_write = 1'b1;
            end
            opc_op_imm, opc_op_imm_32: begin
                dec.alu_op    = alu_from_funct(funct3, 1'b0, alt);
                dec.b_src     = b_imm;
                dec.word      = (opcode == opc_op_imm_32);
                dec.reg_write = 1'b1;
            end
            opc_lui: begin
                dec.alu_op    = alu_pass_b;
                dec.b_src     = b_imm;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            opc_auipc: begin
                dec.a_src     = a_pc;
                dec.b_src     = b_imm;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            opc_jal, opc_jalr: begin
                dec.a_src     = a_pc;  // Link is pc + 4 through the ALU
                dec.b_src     = b_four;
                dec.branch    = (opcode == opc_jal) ? br_jal : br_jalr;
                dec.imm       = (opcode == opc_jal) ? imm_j : imm_i;
                dec.reg_write = 1'b1;
            end
            opc_branch: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.branch = br_beq;
                    3'b001:  dec.branch = br_bne;
                    3'b100:  dec.branch = br_blt;
                    3'b101:  dec.branch = br_bge;
                    3'b110:  dec.branch = br_bltu;
                    3'b111:  dec.branch = br_bgeu;
                    default: dec.branch = br_none;
                endcase
            end
            default: ;
        endcase
    end

    // Execute bypass is younger, so it wins over the result stage
    assign dec.rs1_val = (rs1 != 5'd0 && ex_we && ex_rd == rs1)   ? ex_result  :
                         (rs1 != 5'd0 && res_we && res_rd == rs1) ? res_result : rs1_data;
    assign dec.rs2_val = (rs2 != 5'd0 && ex_we && ex_rd == rs2)   ? ex_result  :
                         (rs2 != 5'd0 && res_we && res_rd == rs2) ? res_result : rs2_data;

    assign dec.pc = pc;
    assign dec.rd = instr[11:7];

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  isa_pkg::alu_op_t         op,
    input  logic                     word,
    input  logic [isa_pkg::xlen-1:0] a,
    input  logic [isa_pkg::xlen-1:0] b,
    output logic [isa_pkg::xlen-1:0] result
);

    import isa_pkg::*;

    logic [5:0]      shamt;
    logic [xlen-1:0] a_lo_zext;
    logic [xlen-1:0] a_lo_sext;
    logic [xlen-1:0] full;

    assign shamt     = word ? {1'b0, b[4:0]} : b[5:0];
    assign a_lo_zext = {{(xlen-32){1'b0}}, a[31:0]};
    assign a_lo_sext = {{(xlen-32){a[31]}}, a[31:0]};

    always_comb begin
        case (op)
            alu_add:    full = a + b;
            alu_sub:    full = a - b;
            alu_sll:    full = a << shamt;
            alu_slt:    full = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   full = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    full = a ^ b;
            alu_srl:    full = word ? (a_lo_zext >> shamt) : (a >> shamt);
            alu_sra:    full = word ? $signed(a_lo_sext) >>> shamt : $signed(a) >>> shamt;
            alu_or:     full = a | b;
            alu_and:    full = a & b;
            alu_pass_b: full = b;
            default:    full = '0;
        endcase
    end

    // Word forms keep 32 bits and sign-extend
    assign result = word ? {{(xlen-32){full[31]}}, full[31:0]} : full;

endmodule

`default_nettype wire

//--- design/next_pc.sv
`timescale 1ns/1ns
`default_nettype none

module next_pc (
    input  isa_pkg::branch_t         kind,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic [isa_pkg::xlen-1:0] rs1_val,
    input  logic [isa_pkg::xlen-1:0] rs2_val,
    input  logic [isa_pkg::xlen-1:0] imm,
    output logic                     taken,
    output logic [isa_pkg::xlen-1:0] target
);

    import isa_pkg::*;

    logic [xlen-1:0] sum;

    always_comb begin
        case (kind)
            br_jal, br_jalr: taken = 1'b1;
            br_beq:          taken = (rs1_val == rs2_val);
            br_bne:          taken = (rs1_val != rs2_val);
            br_blt:          taken = ($signed(rs1_val) < $signed(rs2_val));
            br_bge:          taken = ($signed(rs1_val) >= $signed(rs2_val));
            br_bltu:         taken = (rs1_val < rs2_val);
            br_bgeu:         taken = (rs1_val >= rs2_val);
            default:         taken = 1'b0;
        endcase
    end

    assign sum    = ((kind == br_jalr) ? rs1_val : pc) + imm;
    assign target = {sum[xlen-1:1], 1'b0};  // Bit 0 cleared, matters for jalr only

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic                     valid,
    input  pipe_pkg::dec_ex_t        ex,
    output pipe_pkg::ex_res_t        res,
    output logic                     we,
    output logic                     redirect,
    output logic [isa_pkg::xlen-1:0] redirect_pc
);

    import isa_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic            taken;

    assign op_a = (ex.a_src == a_pc) ? ex.pc : ex.rs1_val;

    always_comb begin
        case (ex.b_src)
            b_imm:   op_b = ex.imm;
            b_four:  op_b = xlen'(4);  // Jumps, gives the link value
            default: op_b = ex.rs2_val;
        endcase
    end

    alu alu_i (
        .op     (ex.alu_op),
        .word   (ex.word),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    next_pc next_pc_i (
        .kind    (ex.branch),
        .pc      (ex.pc),
        .rs1_val (ex.rs1_val),
        .rs2_val (ex.rs2_val),
        .imm     (ex.imm),
        .taken   (taken),
        .target  (redirect_pc)
    );

    assign res.pc        = ex.pc;
    assign res.result    = alu_result;
    assign res.rd        = ex.rd;
    assign res.reg_write = ex.reg_write;

    assign we       = valid && ex.reg_write;  // Also the execute bypass enable
    assign redirect = valid && taken;

endmodule

`default_nettype wire

//--- design/result_unit.sv
`timescale 1ns/1ns
`default_nettype none

module result_unit (
    input  logic                     valid,
    input  pipe_pkg::ex_res_t        res,
    input  logic                     block,
    output logic                     we,
    output logic [4:0]               rd,
    output logic [isa_pkg::xlen-1:0] wdata,
    output logic                     retire_valid,
    output pipe_pkg::retire_t        retire
);

    // A held instruction writes and retires only on its last cycle here
    assign we = valid && res.reg_write && (res.rd != 5'd0) && !block;
    assign rd    = res.rd;
    assign wdata = res.result;

    assign retire_valid = valid && !block;
    assign retire       = res;

endmodule

`default_nettype wire

//--- design/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  logic [31:0]              instr,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic                     valid_in,
    input  logic                     block,
    output logic                     redirect,
    output logic [isa_pkg::xlen-1:0] redirect_pc,
    output logic                     retire_valid,
    output pipe_pkg::retire_t        retire
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [4:0]      rs1, rs2;
    logic [xlen-1:0] rs1_data, rs2_data;
    dec_ex_t         dec_d, dec_q;
    logic            dec_valid;
    ex_res_t         ex_d, ex_q;
    logic            ex_valid;
    logic            ex_we;
    logic            wb_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;

    reg_file reg_file_i (
        .clk, .rst_n,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .we (wb_we), .rd (wb_rd), .wdata (wb_data)
    );

    decode_unit decode_unit_i (
        .instr, .pc, .rs1_data, .rs2_data, .rs1, .rs2,
        .ex_we      (ex_we),
        .ex_rd      (ex_d.rd),
        .ex_result  (ex_d.result),
        .res_we     (wb_we),
        .res_rd     (wb_rd),
        .res_result (wb_data),
        .dec        (dec_d)
    );

    // Taken branch in execute drops the instruction behind it
    pipe_stage_reg #(.payload_t(dec_ex_t)) dec_ex_reg (
        .clk, .rst_n,
        .stall (block), .flush (redirect), .valid_in (valid_in), .data_in (dec_d),
        .valid (dec_valid), .data (dec_q)
    );

    execute_unit execute_unit_i (
        .valid (dec_valid), .ex (dec_q), .res (ex_d), .we (ex_we),
        .redirect, .redirect_pc
    );

    pipe_stage_reg #(.payload_t(ex_res_t)) ex_res_reg (
        .clk, .rst_n,
        .stall (block), .flush (1'b0), .valid_in (dec_valid), .data_in (ex_d),
        .valid (ex_valid), .data (ex_q)
    );

    result_unit result_unit_i (
        .valid (ex_valid), .res (ex_q), .block,
        .we (wb_we), .rd (wb_rd), .wdata (wb_data),
        .retire_valid, .retire
    );

endmodule

`default_nettype wire

//--- tests/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            we;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } retire_exp_t;

    logic            clk;
    logic            rst_n;
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    logic            valid_in;
    logic            block;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    logic            retire_valid;
    retire_t         retire;

    logic [31:0]     prog [$];      // Indexed by pc / 4
    retire_exp_t     expected [$];  // Taken path, program order
    logic [xlen-1:0] targets [$];   // Redirect targets, program order
    int              next_exp;

    core_top dut_i (
        .clk, .rst_n, .instr, .pc, .valid_in, .block,
        .redirect, .redirect_pc, .retire_valid, .retire
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // Expected row for an instruction that retires; rd comes from its encoding
    task automatic record(input logic we, input logic [31:0] word, input logic [xlen-1:0] value);
        retire_exp_t e;
        e.pc    = xlen'(prog.size() * 4);
        e.we    = we;
        e.rd    = we ? word[11:7] : 5'd0;
        e.value = value;
        expected.push_back(e);
        prog.push_back(word);
    endtask

    task automatic writes(input logic [31:0] word, input logic [xlen-1:0] value);
        record(1'b1, word, value);
    endtask

    task automatic retires_only(input logic [31:0] word);
        record(1'b0, word, '0);
    endtask

    task automatic never_retires(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic load_program();
        // Dependent ALU chain, operands come from both bypasses
        writes(i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_op_imm), 64'd5);
        writes(i_type(12'hffd, 5'd0, 3'b000, 5'd2, opc_op_imm), 64'hffffffff_fffffffd);
        writes(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opc_op), 64'd2);   // add
        writes(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, opc_op), 64'd8);   // sub
        writes(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd5, opc_op), 64'd10);  // xor
        writes(r_type(7'h00, 5'd1, 5'd5, 3'b110, 5'd6, opc_op), 64'd15);  // or
        writes(r_type(7'h00, 5'd2, 5'd6, 3'b111, 5'd7, opc_op), 64'd13);  // and
        writes(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8, opc_op), 64'd1);   // slt
        writes(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9, opc_op), 64'd0);   // sltu
        writes(i_type(12'd60, 5'd1, 3'b001, 5'd10, opc_op_imm), 64'h50000000_00000000);
        writes(i_type(12'h401, 5'd2, 3'b101, 5'd11, opc_op_imm), 64'hffffffff_fffffffe);
        writes(i_type(12'd60, 5'd2, 3'b101, 5'd12, opc_op_imm), 64'hf);
        writes(u_type(20'h80000, 5'd13, opc_lui), 64'hffffffff_80000000);
        // Word forms
        writes(i_type(12'hfff, 5'd13, 3'b000, 5'd14, opc_op_imm_32), 64'h00000000_7fffffff);
        writes(r_type(7'h00, 5'd1, 5'd14, 3'b000, 5'd15, opc_op_32), 64'hffffffff_80000004);
        writes(i_type(12'd31, 5'd1, 3'b001, 5'd16, opc_op_imm_32), 64'hffffffff_80000000);
        writes(r_type(7'h20, 5'd1, 5'd15, 3'b101, 5'd17, opc_op_32), 64'hffffffff_fc000000);
        writes(r_type(7'h00, 5'd1, 5'd15, 3'b101, 5'd18, opc_op_32), 64'h00000000_04000000);
        writes(u_type(20'h00001, 5'd19, opc_auipc), 64'h1048);  // At pc 72
        // x0 write, then a read of x0
        writes(i_type(12'd7, 5'd1, 3'b000, 5'd0, opc_op_imm), 64'd12);
        writes(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd20, opc_op), 64'd5);
        // Branches and jumps from pc 84
        retires_only(b_type(13'd8, 5'd3, 5'd1, 3'b000));  // beq, not taken
        retires_only(b_type(13'd8, 5'd3, 5'd1, 3'b001));  // bne to 96
        targets.push_back(64'd96);
        never_retires(i_type(12'd99, 5'd0, 3'b000, 5'd21, opc_op_imm));
        retires_only(b_type(13'd8, 5'd1, 5'd2, 3'b100));  // blt to 104
        targets.push_back(64'd104);
        never_retires(i_type(12'd1, 5'd0, 3'b000, 5'd22, opc_op_imm));
        retires_only(b_type(13'd8, 5'd1, 5'd2, 3'b111));  // bgeu to 112
        targets.push_back(64'd112);
        never_retires(i_type(12'd2, 5'd0, 3'b000, 5'd22, opc_op_imm));
        retires_only(b_type(13'd8, 5'd1, 5'd2, 3'b101));  // bge, not taken
        writes(j_type(21'd8, 5'd23), 64'd120);            // jal to 124
        targets.push_back(64'd124);
        never_retires(i_type(12'd1, 5'd0, 3'b000, 5'd24, opc_op_imm));
        writes(i_type(12'd136, 5'd0, 3'b000, 5'd25, opc_op_imm), 64'd136);
        writes(i_type(12'd1, 5'd25, 3'b000, 5'd26, opc_jalr), 64'd132);  // Target 137 to 136
        targets.push_back(64'd136);
        never_retires(i_type(12'd3, 5'd0, 3'b000, 5'd27, opc_op_imm));
        writes(i_type(12'd4, 5'd26, 3'b000, 5'd28, opc_op_imm), 64'd136);
        writes(j_type(21'd0, 5'd0), 64'd144);             // Spins here at pc 140
        targets.push_back(64'd140);
        never_retires(i_type(12'hfff, 5'd0, 3'b000, 5'd31, opc_op_imm));
    endtask

    task automatic present_fetch();
        int idx;
        idx = int'(pc >> 2);
        if (idx < prog.size()) begin
            instr = prog[idx];
        end else begin
            stop_with_failure($sformatf("Fetch left the program at pc %h", pc));
        end
    endtask

    task automatic check_retire();
        retire_exp_t e;
        e = expected[next_exp];
        check_value("retire.pc", retire.pc, e.pc);
        check_value("retire.reg_write", 64'(retire.reg_write), 64'(e.we));
        if (e.we) begin
            check_value("retire.rd", 64'(retire.rd), 64'(e.rd));
            if (e.rd != 5'd0) begin
                check_value("retire.result", retire.result, e.value);
            end
        end
        next_exp++;
    endtask

    // A redirect that takes effect must match the next taken-path target
    task automatic check_redirect(input logic [xlen-1:0] got);
        if (targets.size() == 0) begin
            stop_with_failure($sformatf("Redirect to %h with no taken branch or jump pending",
                                        got));
        end else begin
            check_value("redirect_pc", got, targets.pop_front());
        end
    endtask

    initial begin
        logic            take_redirect;
        logic [xlen-1:0] target;
        logic            held;
        int              cycles;

        void'($urandom(32'h8313_cd1e));
        rst_n    = 1'b0;
        valid_in = 1'b0;
        block    = 1'b0;
        pc       = '0;
        next_exp = 0;
        load_program();
        present_fetch();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("retire_valid", 64'(retire_valid), 64'd0);  // Pipeline empty in reset
        check_value("redirect", 64'(redirect), 64'd0);
        @(posedge clk);
        #1;
        rst_n    = 1'b1;
        valid_in = 1'b1;
        cycles   = 0;
        while (next_exp < expected.size()) begin
            @(negedge clk);
            if (retire_valid) begin
                check_retire();
            end
            take_redirect = redirect;
            target        = redirect_pc;
            held          = block;
            if (take_redirect && !held) begin
                check_redirect(target);
            end
            @(posedge clk);
            #1;
            if (!held) begin
                pc = take_redirect ? target : pc + 64'd4;
                present_fetch();
            end
            block = ($urandom % 4) == 0;
            cycles++;
            if (cycles > 400) begin
                stop_with_failure("Timed out waiting for the expected retire reports");
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_stage_reg.sv
design/reg_file.sv
design/decode_unit.sv
design/alu.sv
design/next_pc.sv
design/execute_unit.sv
design/result_unit.sv
design/core_top.sv
tests/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for a failure in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module core_tb -f all.f -o core_tb_sim || exit 1
./obj_dir/core_tb_sim 2>&1 | tee sim.log
grep -q "RESULT: PASS" sim.log && ! grep -q "RESULT: FAIL" sim.log || exit 1
